// ==== files.f ====
+incdir+tb
src/frontend_pkg.sv
src/pc_gen.sv
src/bht.sv
src/btb.sv
src/bpu.sv
src/inst_buffer.sv
src/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_fetch_frontend -o sim_fetch \
    && ./obj_dir/sim_fetch \
    || { echo "simulation returned a failing status"; exit 1; }

// ==== tb/frontend_model.svh ====
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// one fetched slot as decode should see it
typedef struct packed {
    frontend_pkg::addr_t pc;
    frontend_pkg::inst_t inst;
    logic                fault;
    logic                taken;
    frontend_pkg::addr_t target;
} entry_t;

frontend_pkg::ctr_t  m_bht        [2**BHT_BITS];
logic                m_btb_valid  [2**BTB_BITS];
frontend_pkg::addr_t m_btb_pc     [2**BTB_BITS];
frontend_pkg::addr_t m_btb_target [2**BTB_BITS];
frontend_pkg::addr_t m_pc;
entry_t              m_q [$];

////////////////////////////////////////////////////////////
// memory image
////////////////////////////////////////////////////////////

// roughly 77 of 256 words are branches
function automatic frontend_pkg::inst_t mem_word(input frontend_pkg::addr_t a);
    logic [31:0]           h;
    frontend_pkg::opcode_t op;
    h = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    if (h[31:24] < 8'd77) begin
        op = frontend_pkg::BR_OP_LO + frontend_pkg::opcode_t'(h[3:0] % 4'd10);
    end else begin
        op = h[5:0];
        // push it out of the branch range
        if (op >= frontend_pkg::BR_OP_LO && op <= frontend_pkg::BR_OP_HI) begin
            op = op ^ 6'h20;
        end
    end
    return {op, h[25:0]};
endfunction

function automatic logic mem_fault(input frontend_pkg::addr_t a);
    return &a[9:7];
endfunction

////////////////////////////////////////////////////////////
// predictor tables
////////////////////////////////////////////////////////////

// slot contents and prediction for one fetch address
function automatic entry_t fetch_slot(input frontend_pkg::addr_t a);
    entry_t                e;
    frontend_pkg::opcode_t op;
    logic                  hit;
    logic                  branch;
    e.pc     = a;
    e.inst   = mem_word(a);
    e.fault  = mem_fault(a);
    op       = e.inst[31:26];
    branch   = (op >= frontend_pkg::BR_OP_LO) && (op <= frontend_pkg::BR_OP_HI);
    hit      = m_btb_valid[a[BTB_BITS+1:2]]
               && (m_btb_pc[a[BTB_BITS+1:2]][31:BTB_BITS+2] == a[31:BTB_BITS+2]);
    e.taken  = branch && (m_bht[a[BHT_BITS+1:2]] >= 2'd2) && hit;
    e.target = m_btb_target[a[BTB_BITS+1:2]];
    return e;
endfunction

task automatic model_train(input frontend_pkg::addr_t pc, input logic taken,
                           input frontend_pkg::addr_t target);
    frontend_pkg::ctr_t c;
    c = m_bht[pc[BHT_BITS+1:2]];
    if (taken) begin
        c = (c == 2'd3) ? c : c + 2'd1;
        m_btb_valid[pc[BTB_BITS+1:2]]  = 1'b1;
        m_btb_pc[pc[BTB_BITS+1:2]]     = pc;
        m_btb_target[pc[BTB_BITS+1:2]] = target;
    end else begin
        c = (c == 2'd0) ? c : c - 2'd1;
    end
    m_bht[pc[BHT_BITS+1:2]] = c;
endtask

task automatic model_reset();
    for (int i = 0; i < 2**BHT_BITS; i++) begin
        m_bht[i] = frontend_pkg::CTR_RESET;
    end
    for (int i = 0; i < 2**BTB_BITS; i++) begin
        m_btb_valid[i]  = 1'b0;
        m_btb_pc[i]     = '0;
        m_btb_target[i] = '0;
    end
    m_pc = RESET_PC;
    m_q.delete();
endtask

`endif

// ==== tb/tb_fetch_frontend.sv ====
module tb_fetch_frontend;

    localparam frontend_pkg::addr_t RESET_PC   = 32'h1c00_0000;
    localparam int                  BHT_BITS   = 6;
    localparam int                  BTB_BITS   = 4;
    localparam int                  FIFO_DEPTH = 8;

    localparam int          RESET_CYCLES   = 16;
    localparam int          RUN_CYCLES     = 3000;
    // run length plus reset and some slack
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + 200;
    localparam logic [31:0] SEED           = 32'h22e1_df37;
    // 1 KB window for flush and training addresses
    localparam int          WINDOW_WORDS   = 256;

    logic                clk = 1'b0;
    logic                arst_n;
    frontend_pkg::addr_t fetch_pc;
    frontend_pkg::inst_t imem_inst_1;
    frontend_pkg::inst_t imem_inst_2;
    logic                imem_fault_1;
    logic                imem_fault_2;
    logic                out_valid;
    logic                out_ready;
    frontend_pkg::addr_t out_pc;
    frontend_pkg::inst_t out_inst;
    logic                out_pred_taken;
    frontend_pkg::addr_t out_pred_target;
    logic                out_exception;
    logic                flush;
    frontend_pkg::addr_t flush_pc;
    logic                upd_en;
    frontend_pkg::addr_t upd_pc;
    logic                upd_taken;
    frontend_pkg::addr_t upd_target;

    int                  cycle_cnt;
    int                  taken_pops;
    int                  fault_pops;
    logic                flush_seen;
    frontend_pkg::addr_t flush_target;
    logic                hold_seen;
    frontend_pkg::addr_t hold_pc;

    `include "frontend_model.svh"

    fetch_frontend #(
        .RESET_PC(RESET_PC), .BHT_BITS(BHT_BITS), .BTB_BITS(BTB_BITS), .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fetch_frontend (
        .clk(clk), .arst_n(arst_n), .fetch_pc(fetch_pc),
        .imem_inst_1(imem_inst_1), .imem_inst_2(imem_inst_2),
        .imem_fault_1(imem_fault_1), .imem_fault_2(imem_fault_2),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_inst(out_inst), .out_pred_taken(out_pred_taken),
        .out_pred_target(out_pred_target), .out_exception(out_exception),
        .flush(flush), .flush_pc(flush_pc), .upd_en(upd_en), .upd_pc(upd_pc),
        .upd_taken(upd_taken), .upd_target(upd_target)
    );

    // instruction memory answers in the same cycle
    assign imem_inst_1  = mem_word(fetch_pc);
    assign imem_inst_2  = mem_word(fetch_pc + 32'd4);
    assign imem_fault_1 = mem_fault(fetch_pc);
    assign imem_fault_2 = mem_fault(fetch_pc + 32'd4);

    initial begin
        forever begin
            #20 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // compare outputs, then advance the model to the next edge
    task automatic compare_and_step();
        entry_t e1;
        entry_t e2;
        logic   stall_exp;
        logic   pop;
        if (flush_seen) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_word("fetch_pc", fetch_pc, flush_target);
        end
        if (hold_seen) begin
            check_word("fetch_pc", fetch_pc, hold_pc);
        end
        check_word("fetch_pc", fetch_pc, m_pc);
        check_bit("out_valid", out_valid, m_q.size() != 0);
        if (m_q.size() != 0) begin
            check_word("out_pc", out_pc, m_q[0].pc);
            check_word("out_inst", out_inst, m_q[0].inst);
            check_bit("out_exception", out_exception, m_q[0].fault);
            check_bit("out_pred_taken", out_pred_taken, m_q[0].taken);
            if (m_q[0].taken) begin
                check_word("out_pred_target", out_pred_target, m_q[0].target);
            end
        end

        stall_exp = m_q.size() > FIFO_DEPTH - 2;
        pop       = (m_q.size() != 0) && out_ready && !flush;
        e1        = fetch_slot(m_pc);
        e2        = fetch_slot(m_pc + 32'd4);

        flush_seen   = flush;
        flush_target = flush_pc;
        hold_seen    = !flush && stall_exp;
        hold_pc      = m_pc;

        if (pop) begin
            if (m_q[0].taken) begin
                taken_pops++;
            end
            if (m_q[0].fault) begin
                fault_pops++;
            end
            void'(m_q.pop_front());
        end
        if (flush) begin
            m_q.delete();
            m_pc = flush_pc;
        end else if (!stall_exp) begin
            m_q.push_back(e1);
            if (e1.taken) begin
                // slot 2 is off the predicted path
                m_pc = e1.target;
            end else begin
                m_q.push_back(e2);
                m_pc = e2.taken ? e2.target : m_pc + 32'd8;
            end
        end
        // training sees the tables as they were during this cycle's lookup
        if (upd_en) begin
            model_train(upd_pc, upd_taken, upd_target);
        end
    endtask

    // inputs are stable here, half a period after they were driven
    always @(negedge clk) begin
        if (!arst_n) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_word("fetch_pc", fetch_pc, RESET_PC);
            model_reset();
            flush_seen = 1'b0;
            hold_seen  = 1'b0;
        end else begin
            compare_and_step();
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic frontend_pkg::addr_t random_window_pc();
        return RESET_PC + (($urandom % WINDOW_WORDS) << 2);
    endfunction

    task automatic drive_random();
        out_ready <= ($urandom % 100) < 70;
        if (($urandom % 100) < 2) begin
            flush    <= 1'b1;
            flush_pc <= random_window_pc();
        end else begin
            flush <= 1'b0;
        end
        // training mostly reports taken branches
        upd_en     <= ($urandom % 100) < 25;
        upd_pc     <= random_window_pc();
        upd_taken  <= ($urandom % 100) < 80;
        upd_target <= random_window_pc();
    endtask

    initial begin
        arst_n       = 1'b0;
        out_ready    = 1'b0;
        flush        = 1'b0;
        flush_pc     = '0;
        upd_en       = 1'b0;
        upd_pc       = '0;
        upd_taken    = 1'b0;
        upd_target   = '0;
        cycle_cnt    = 0;
        taken_pops   = 0;
        fault_pops   = 0;
        flush_seen   = 1'b0;
        flush_target = '0;
        hold_seen    = 1'b0;
        hold_pc      = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            drive_random();
        end
        // last compare ran on the negedge before this edge
        @(posedge clk);

        if (taken_pops == 0 || fault_pops == 0) begin
            $display("no predicted-taken or no faulting entry reached decode during the run");
            $display("RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== src/fetch_frontend.sv ====
module fetch_frontend #(
    parameter frontend_pkg::addr_t RESET_PC   = 32'h1c00_0000,
    parameter int                  BHT_BITS   = 6,
    parameter int                  BTB_BITS   = 4,
    parameter int                  FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    // instruction memory
    output frontend_pkg::addr_t fetch_pc,
    input  frontend_pkg::inst_t imem_inst_1,
    input  frontend_pkg::inst_t imem_inst_2,
    input  logic                imem_fault_1,
    input  logic                imem_fault_2,
    // decode
    output logic                out_valid,
    input  logic                out_ready,
    output frontend_pkg::addr_t out_pc,
    output frontend_pkg::inst_t out_inst,
    output logic                out_pred_taken,
    output frontend_pkg::addr_t out_pred_target,
    output logic                out_exception,
    // back end
    input  logic                flush,
    input  frontend_pkg::addr_t flush_pc,
    input  logic                upd_en,
    input  frontend_pkg::addr_t upd_pc,
    input  logic                upd_taken,
    input  frontend_pkg::addr_t upd_target
);

    frontend_pkg::addr_t fetch_pc_2;
    frontend_pkg::ctr_t  ctr_1;
    frontend_pkg::ctr_t  ctr_2;
    logic                hit_1;
    logic                hit_2;
    frontend_pkg::addr_t target_1;
    frontend_pkg::addr_t target_2;
    logic                push_1;
    logic                push_2;
    logic                pred_taken_1;
    logic                pred_taken_2;
    logic                redirect_en;
    frontend_pkg::addr_t redirect_pc;
    logic                stall;

    // second slot address for the predictor read ports
    assign fetch_pc_2 = fetch_pc + 32'd4;

    pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
        .clk(clk), .arst_n(arst_n), .redirect_en(redirect_en),
        .redirect_pc(redirect_pc), .stall(stall), .fetch_pc(fetch_pc)
    );

    bht #(.BHT_BITS(BHT_BITS)) u_bht (
        .clk(clk), .arst_n(arst_n), .pc_1(fetch_pc), .pc_2(fetch_pc_2),
        .upd_en(upd_en), .upd_pc(upd_pc), .upd_taken(upd_taken),
        .ctr_1(ctr_1), .ctr_2(ctr_2)
    );

    // only taken branches allocate a target
    btb #(.BTB_BITS(BTB_BITS)) u_btb (
        .clk(clk), .arst_n(arst_n), .pc_1(fetch_pc), .pc_2(fetch_pc_2),
        .wr_en(upd_en && upd_taken), .wr_pc(upd_pc), .wr_target(upd_target),
        .hit_1(hit_1), .hit_2(hit_2), .target_1(target_1), .target_2(target_2)
    );

    bpu u_bpu (
        .fetch_pc(fetch_pc), .inst_1(imem_inst_1), .inst_2(imem_inst_2),
        .ctr_1(ctr_1), .ctr_2(ctr_2), .hit_1(hit_1), .hit_2(hit_2),
        .target_1(target_1), .target_2(target_2), .stall(stall),
        .flush(flush), .flush_pc(flush_pc), .push_1(push_1), .push_2(push_2),
        .pred_taken_1(pred_taken_1), .pred_taken_2(pred_taken_2),
        .redirect_en(redirect_en), .redirect_pc(redirect_pc)
    );

    inst_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) u_inst_buffer (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .push_1(push_1), .push_2(push_2), .pc_1(fetch_pc),
        .inst_1(imem_inst_1), .fault_1(imem_fault_1),
        .taken_1(pred_taken_1), .target_1(target_1),
        .inst_2(imem_inst_2), .fault_2(imem_fault_2),
        .taken_2(pred_taken_2), .target_2(target_2),
        .out_ready(out_ready), .stall(stall), .out_valid(out_valid),
        .out_pc(out_pc), .out_inst(out_inst), .out_pred_taken(out_pred_taken),
        .out_pred_target(out_pred_target), .out_exception(out_exception)
    );

endmodule

// ==== src/inst_buffer.sv ====
module inst_buffer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                push_1,
    input  logic                push_2,
    input  frontend_pkg::addr_t pc_1,
    input  frontend_pkg::inst_t inst_1,
    input  logic                fault_1,
    input  logic                taken_1,
    input  frontend_pkg::addr_t target_1,
    input  frontend_pkg::inst_t inst_2,
    input  logic                fault_2,
    input  logic                taken_2,
    input  frontend_pkg::addr_t target_2,
    input  logic                out_ready,
    output logic                stall,
    output logic                out_valid,
    output frontend_pkg::addr_t out_pc,
    output frontend_pkg::inst_t out_inst,
    output logic                out_pred_taken,
    output frontend_pkg::addr_t out_pred_target,
    output logic                out_exception
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////

    frontend_pkg::addr_t pc_mem     [FIFO_DEPTH];
    frontend_pkg::inst_t inst_mem   [FIFO_DEPTH];
    logic                fault_mem  [FIFO_DEPTH];
    logic                taken_mem  [FIFO_DEPTH];
    frontend_pkg::addr_t target_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0]    wr_idx_2;
    logic                pop;
    frontend_pkg::addr_t pc_2;

    // slot 2 sits right behind slot 1
    assign pc_2     = pc_1 + 32'd4;
    assign wr_idx_2 = wr_ptr + PTR_W'(push_1);

    // no pop while the buffer is being cleared
    assign pop = out_valid && out_ready && !flush;

    // keeps room for a full two-wide fetch
    assign stall = count > CNT_W'(FIFO_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (push_1) begin
            pc_mem[wr_ptr]     <= pc_1;
            inst_mem[wr_ptr]   <= inst_1;
            fault_mem[wr_ptr]  <= fault_1;
            taken_mem[wr_ptr]  <= taken_1;
            target_mem[wr_ptr] <= target_1;
        end
        if (push_2) begin
            pc_mem[wr_idx_2]     <= pc_2;
            inst_mem[wr_idx_2]   <= inst_2;
            fault_mem[wr_idx_2]  <= fault_2;
            taken_mem[wr_idx_2]  <= taken_2;
            target_mem[wr_idx_2] <= target_2;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_1) + PTR_W'(push_2);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + CNT_W'(push_1) + CNT_W'(push_2) - CNT_W'(pop);
        end
    end

    // head entry
    assign out_valid       = count != '0;
    assign out_pc          = pc_mem[rd_ptr];
    assign out_inst        = inst_mem[rd_ptr];
    assign out_pred_taken  = taken_mem[rd_ptr];
    assign out_pred_target = target_mem[rd_ptr];
    assign out_exception   = fault_mem[rd_ptr];

endmodule

// ==== src/bpu.sv ====
module bpu (
    input  frontend_pkg::addr_t fetch_pc,
    input  frontend_pkg::inst_t inst_1,
    input  frontend_pkg::inst_t inst_2,
    input  frontend_pkg::ctr_t  ctr_1,
    input  frontend_pkg::ctr_t  ctr_2,
    input  logic                hit_1,
    input  logic                hit_2,
    input  frontend_pkg::addr_t target_1,
    input  frontend_pkg::addr_t target_2,
    input  logic                stall,
    input  logic                flush,
    input  frontend_pkg::addr_t flush_pc,
    output logic                push_1,
    output logic                push_2,
    output logic                pred_taken_1,
    output logic                pred_taken_2,
    output logic                redirect_en,
    output frontend_pkg::addr_t redirect_pc
);

    ////////////////////////////////////////////////////////////
    // predecode
    ////////////////////////////////////////////////////////////

    // branch opcodes form one contiguous range
    function automatic logic is_branch(input frontend_pkg::inst_t inst);
        frontend_pkg::opcode_t op;
        op = inst[31:26];
        return (op >= frontend_pkg::BR_OP_LO) && (op <= frontend_pkg::BR_OP_HI);
    endfunction

    logic br_1;
    logic br_2;

    assign br_1 = is_branch(inst_1);
    assign br_2 = is_branch(inst_2);

    // taken needs a branch, a taken counter and a target
    assign pred_taken_1 = br_1 && ctr_1[1] && hit_1;
    assign pred_taken_2 = br_2 && ctr_2[1] && hit_2;

    ////////////////////////////////////////////////////////////
    // slot enables and next pc
    ////////////////////////////////////////////////////////////

    always_comb begin
        push_1      = 1'b0;
        push_2      = 1'b0;
        redirect_en = 1'b0;
        redirect_pc = fetch_pc + 32'd8;

        if (flush) begin
            // back end redirect, drop this fetch
            redirect_en = 1'b1;
            redirect_pc = flush_pc;
        end else if (stall) begin
            // buffer nearly full, hold pc
            redirect_pc = fetch_pc;
        end else if (pred_taken_1) begin
            // slot 2 lies on the wrong path
            push_1      = 1'b1;
            redirect_en = 1'b1;
            redirect_pc = target_1;
        end else if (pred_taken_2) begin
            push_1      = 1'b1;
            push_2      = 1'b1;
            redirect_en = 1'b1;
            redirect_pc = target_2;
        end else begin
            // fall through
            push_1 = 1'b1;
            push_2 = 1'b1;
        end
    end

endmodule

// ==== src/btb.sv ====
module btb #(
    parameter int BTB_BITS = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  frontend_pkg::addr_t pc_1,
    input  frontend_pkg::addr_t pc_2,
    input  logic                wr_en,
    input  frontend_pkg::addr_t wr_pc,
    input  frontend_pkg::addr_t wr_target,
    output logic                hit_1,
    output logic                hit_2,
    output frontend_pkg::addr_t target_1,
    output frontend_pkg::addr_t target_2
);

    localparam int BTB_ENTRIES = 2 ** BTB_BITS;
    localparam int TAG_W       = 32 - BTB_BITS - 2;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    logic                valid_tbl  [BTB_ENTRIES];
    logic [TAG_W-1:0]    tag_tbl    [BTB_ENTRIES];
    frontend_pkg::addr_t target_tbl [BTB_ENTRIES];

    logic [BTB_BITS-1:0] idx_1;
    logic [BTB_BITS-1:0] idx_2;
    logic [BTB_BITS-1:0] wr_idx;

    assign idx_1  = pc_1[BTB_BITS+1:2];
    assign idx_2  = pc_2[BTB_BITS+1:2];
    assign wr_idx = wr_pc[BTB_BITS+1:2];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // hit needs valid entry and full tag match
    assign hit_1    = valid_tbl[idx_1] && (tag_tbl[idx_1] == pc_1[31:BTB_BITS+2]);
    assign hit_2    = valid_tbl[idx_2] && (tag_tbl[idx_2] == pc_2[31:BTB_BITS+2]);
    assign target_1 = target_tbl[idx_1];
    assign target_2 = target_tbl[idx_2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_tbl[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_tbl[wr_idx] <= 1'b1;
        end
    end

    // tag and target, written together with the valid bit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_tbl[wr_idx]    <= wr_pc[31:BTB_BITS+2];
            target_tbl[wr_idx] <= wr_target;
        end
    end

endmodule

// ==== src/bht.sv ====
module bht #(
    parameter int BHT_BITS = 6
) (
    input  logic                clk,
    input  logic                arst_n,
    input  frontend_pkg::addr_t pc_1,
    input  frontend_pkg::addr_t pc_2,
    input  logic                upd_en,
    input  frontend_pkg::addr_t upd_pc,
    input  logic                upd_taken,
    output frontend_pkg::ctr_t  ctr_1,
    output frontend_pkg::ctr_t  ctr_2
);

    localparam int BHT_ENTRIES = 2 ** BHT_BITS;

    frontend_pkg::ctr_t ctr_tbl [BHT_ENTRIES];

    logic [BHT_BITS-1:0] idx_1;
    logic [BHT_BITS-1:0] idx_2;
    logic [BHT_BITS-1:0] upd_idx;

    // word index, byte offset dropped
    assign idx_1   = pc_1[BHT_BITS+1:2];
    assign idx_2   = pc_2[BHT_BITS+1:2];
    assign upd_idx = upd_pc[BHT_BITS+1:2];

    // read ports, old contents during an update
    assign ctr_1 = ctr_tbl[idx_1];
    assign ctr_2 = ctr_tbl[idx_2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_tbl[i] <= frontend_pkg::CTR_RESET;
            end
        end else if (upd_en) begin
            // saturate at 3 and at 0
            if (upd_taken && ctr_tbl[upd_idx] != 2'd3) begin
                ctr_tbl[upd_idx] <= ctr_tbl[upd_idx] + 2'd1;
            end else if (!upd_taken && ctr_tbl[upd_idx] != 2'd0) begin
                ctr_tbl[upd_idx] <= ctr_tbl[upd_idx] - 2'd1;
            end
        end
    end

endmodule

// ==== src/pc_gen.sv ====
module pc_gen #(
    parameter frontend_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                redirect_en,
    input  frontend_pkg::addr_t redirect_pc,
    input  logic                stall,
    output frontend_pkg::addr_t fetch_pc
);

    frontend_pkg::addr_t pc_q;
    frontend_pkg::addr_t pc_next;

    // redirect wins over stall, bpu already masks
    // predicted redirects while stalled
    always_comb begin
        if (redirect_en) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc_q;
        end else begin
            // two words per fetch
            pc_next = pc_q + 32'd8;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

endmodule

// ==== src/frontend_pkg.sv ====
package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // vector types with a meaning
    ////////////////////////////////////////////////////////////

    // byte address of an instruction word
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // 2-bit direction counter, msb set means taken
    typedef logic [1:0] ctr_t;

    // major opcode field, inst[31:26]
    typedef logic [5:0] opcode_t;

    ////////////////////////////////////////////////////////////
    // constants shared with the testbench model
    ////////////////////////////////////////////////////////////

    // inclusive range of branch opcodes
    localparam opcode_t BR_OP_LO = 6'h12;
    localparam opcode_t BR_OP_HI = 6'h1b;

    // weakly not taken
    localparam ctr_t CTR_RESET = 2'd1;

endpackage
